//--- hw/uf_decoder_pkg.sv
`default_nettype none

package uf_decoder_pkg;

    localparam int STAGE_WIDTH = 3;

    typedef enum logic [STAGE_WIDTH-1:0] {
        STAGE_IDLE                = 3'd0,
        STAGE_MEASUREMENT_LOADING = 3'd1,
        STAGE_GROW                = 3'd2,
        STAGE_MERGE               = 3'd3,
        STAGE_PEELING             = 3'd4,
        STAGE_RESULT              = 3'd5
    } stage_t;

    // Index 0 is the lower edge, index 1 the upper edge
    localparam int NEIGHBOR_COUNT = 2;

    // Flag offsets above the root field of the exposed word
    localparam int FIELD_PARENT           = 0;
    localparam int FIELD_PARENT_ODD       = 1; // Odd passed from parent to child
    localparam int FIELD_PARITY           = 2;
    localparam int FIELD_BOUNDARY         = 3;
    localparam int FIELD_PEEL_COMPLETE    = 4;
    localparam int FIELD_PEEL_M           = 5;
    localparam int FIELD_PEEL_PARITY_DONE = 6;
    localparam int EXPOSED_EXTRA          = 7;

    // Unit stage register plus registered busy
    localparam int MERGE_SETTLE = 3;

endpackage

`default_nettype wire

//--- hw/neighbor_link_if.sv
`default_nettype none

interface neighbor_link_if #(
    parameter int ADDRESS_WIDTH = 3
);
    import uf_decoder_pkg::*;

    logic increase_low;
    logic increase_high;
    logic fully_grown;
    logic is_boundary;
    logic error_low;
    logic error_high;
    logic [ADDRESS_WIDTH+EXPOSED_EXTRA-1:0] data_up;   // Lower unit to upper unit
    logic [ADDRESS_WIDTH+EXPOSED_EXTRA-1:0] data_down; // Upper unit to lower unit

    modport edge_side (
        input  increase_low, increase_high, error_low, error_high,
        output fully_grown, is_boundary
    );

    // Unit below the edge
    modport low_side (
        output increase_low, error_low, data_up,
        input  fully_grown, is_boundary, data_down
    );

    // Unit above the edge
    modport high_side (
        output increase_high, error_high, data_down,
        input  fully_grown, is_boundary, data_up
    );

endinterface

`default_nettype wire

//--- hw/root_min_select.sv
`default_nettype none

module root_min_select #(
    parameter int DATA_WIDTH    = 3,
    parameter int CHANNEL_COUNT = 2
) (
    input  logic [CHANNEL_COUNT-1:0][DATA_WIDTH-1:0] values,
    input  logic [CHANNEL_COUNT-1:0]                 valids,
    output logic [DATA_WIDTH-1:0]                    result,
    output logic [CHANNEL_COUNT-1:0]                 result_valids
);

    logic [DATA_WIDTH-1:0] best;
    logic found;

    always_comb begin
        best = '1;
        found = 1'b0;
        for (int c = 0; c < CHANNEL_COUNT; c++) begin
            if (valids[c] && (!found || values[c] < best)) begin
                best = values[c];
                found = 1'b1;
            end
        end
    end

    // Every valid channel carrying the minimum
    always_comb begin
        for (int c = 0; c < CHANNEL_COUNT; c++) begin
            result_valids[c] = valids[c] && (values[c] == best);
        end
    end

    assign result = best;

endmodule

`default_nettype wire

//--- hw/neighbor_link.sv
`default_nettype none

module neighbor_link #(
    parameter bit IS_BOUNDARY = 1'b0
) (
    input  logic                  clk,
    input  logic                  reset,
    input  uf_decoder_pkg::stage_t global_stage,
    neighbor_link_if.edge_side    link,
    output logic                  marked
);
    import uf_decoder_pkg::*;

    logic [1:0] growth;
    logic [2:0] growth_sum;

    // Both sides may grow in the same cycle
    assign growth_sum = growth + link.increase_low + link.increase_high;

    always_ff @(posedge clk) begin
        if (reset) begin
            growth <= 2'd0;
            marked <= 1'b0;
        end else if (global_stage == STAGE_MEASUREMENT_LOADING) begin
            growth <= 2'd0;
            marked <= 1'b0;
        end else begin
            growth <= (growth_sum >= 3'd2) ? 2'd2 : growth_sum[1:0]; // Weight 2
            if (link.error_low || link.error_high) begin
                marked <= 1'b1;
            end
        end
    end

    assign link.fully_grown = (growth == 2'd2);
    assign link.is_boundary = IS_BOUNDARY && link.fully_grown;

endmodule

`default_nettype wire

//--- hw/processing_unit.sv
`default_nettype none

module processing_unit #(
    parameter int ADDRESS_WIDTH = 3,
    parameter int ADDRESS       = 0
) (
    input  logic                   clk,
    input  logic                   reset,
    input  uf_decoder_pkg::stage_t global_stage,
    input  logic                   measurement,
    neighbor_link_if.high_side     low_edge,
    neighbor_link_if.low_side      high_edge,
    output logic                   odd,
    output logic                   busy
);
    import uf_decoder_pkg::*;

    localparam int WORD_WIDTH = ADDRESS_WIDTH + EXPOSED_EXTRA;

    stage_t stage;
    logic m;
    logic [ADDRESS_WIDTH-1:0] root;
    logic [NEIGHBOR_COUNT-1:0] parent_vector;
    logic [NEIGHBOR_COUNT-1:0] odd_to_children;
    logic cluster_parity;
    logic cluster_boundary;
    logic peel_complete;
    logic peel_m;
    logic peel_parity_done;

    logic [NEIGHBOR_COUNT-1:0][WORD_WIDTH-1:0] in_word;
    logic [NEIGHBOR_COUNT-1:0][WORD_WIDTH-1:0] out_word;
    logic [NEIGHBOR_COUNT-1:0][ADDRESS_WIDTH-1:0] nb_root;
    logic [NEIGHBOR_COUNT-1:0] nb_child;
    logic [NEIGHBOR_COUNT-1:0] parent_odd;
    logic [NEIGHBOR_COUNT-1:0] child_parity;
    logic [NEIGHBOR_COUNT-1:0] child_boundary;
    logic [NEIGHBOR_COUNT-1:0] child_complete;
    logic [NEIGHBOR_COUNT-1:0] child_m;
    logic [NEIGHBOR_COUNT-1:0] parent_done;
    logic [NEIGHBOR_COUNT-1:0] fully_grown;
    logic [NEIGHBOR_COUNT-1:0] is_boundary;
    logic [NEIGHBOR_COUNT-1:0] win_valids;
    logic [ADDRESS_WIDTH-1:0] win_root;
    logic [NEIGHBOR_COUNT-1:0] edge_error;
    logic adopt;
    logic next_parity;
    logic next_boundary;
    logic next_odd;
    logic carry;
    logic at_boundary;
    logic ready;

    // Lowest set bit wins
    function automatic logic [NEIGHBOR_COUNT-1:0] lowest_one(input logic [NEIGHBOR_COUNT-1:0] v);
        return v & (~v + 1'b1);
    endfunction

    assign in_word[0] = low_edge.data_up;
    assign in_word[1] = high_edge.data_down;
    assign low_edge.data_down = out_word[0];
    assign high_edge.data_up = out_word[1];
    assign fully_grown = {high_edge.fully_grown, low_edge.fully_grown};
    assign is_boundary = {high_edge.is_boundary, low_edge.is_boundary};

    always_comb begin
        for (int i = 0; i < NEIGHBOR_COUNT; i++) begin
            nb_root[i]        = in_word[i][ADDRESS_WIDTH-1:0];
            nb_child[i]       = in_word[i][ADDRESS_WIDTH+FIELD_PARENT]; // Neighbor points at us
            parent_odd[i]     = in_word[i][ADDRESS_WIDTH+FIELD_PARENT_ODD];
            child_parity[i]   = in_word[i][ADDRESS_WIDTH+FIELD_PARITY];
            child_boundary[i] = in_word[i][ADDRESS_WIDTH+FIELD_BOUNDARY];
            child_complete[i] = in_word[i][ADDRESS_WIDTH+FIELD_PEEL_COMPLETE];
            child_m[i]        = in_word[i][ADDRESS_WIDTH+FIELD_PEEL_M];
            parent_done[i]    = in_word[i][ADDRESS_WIDTH+FIELD_PEEL_PARITY_DONE];
            out_word[i][ADDRESS_WIDTH-1:0]                = root;
            out_word[i][ADDRESS_WIDTH+FIELD_PARENT]           = parent_vector[i];
            out_word[i][ADDRESS_WIDTH+FIELD_PARENT_ODD]       = odd_to_children[i];
            out_word[i][ADDRESS_WIDTH+FIELD_PARITY]           = cluster_parity;
            out_word[i][ADDRESS_WIDTH+FIELD_BOUNDARY]         = cluster_boundary;
            out_word[i][ADDRESS_WIDTH+FIELD_PEEL_COMPLETE]    = peel_complete;
            out_word[i][ADDRESS_WIDTH+FIELD_PEEL_M]           = peel_m;
            out_word[i][ADDRESS_WIDTH+FIELD_PEEL_PARITY_DONE] = peel_parity_done;
        end
    end

    root_min_select #(
        .DATA_WIDTH   (ADDRESS_WIDTH),
        .CHANNEL_COUNT(NEIGHBOR_COUNT)
    ) root_min_select_i (
        .values       (nb_root),
        .valids       (fully_grown & ~is_boundary),
        .result       (win_root),
        .result_valids(win_valids)
    );

    assign adopt = (|win_valids) && (win_root < root);
    assign next_parity = m ^ (^(nb_child & child_parity));
    assign next_boundary = (|(nb_child & child_boundary)) | (|is_boundary);
    assign next_odd = (|parent_vector) ? (|(parent_vector & parent_odd))
                                       : (next_parity & ~next_boundary);

    // Root starts from its own parity, others take the parent's odd
    assign carry = (|parent_vector) ? (|(parent_vector & parent_odd)) : cluster_parity;
    assign at_boundary = |is_boundary;
    assign ready = peel_parity_done && !(|(nb_child & ~child_complete));

    assign low_edge.increase_high = odd && (stage == STAGE_GROW);
    assign high_edge.increase_low = odd && (stage == STAGE_GROW);

    always_comb begin
        edge_error = '0;
        if (stage == STAGE_PEELING && ready) begin
            edge_error = nb_child & child_m;
            if (odd) begin
                edge_error = edge_error | lowest_one(is_boundary);
            end
        end
    end

    assign low_edge.error_high = edge_error[0];
    assign high_edge.error_low = edge_error[1];

    always_ff @(posedge clk) begin
        if (reset) begin
            stage <= STAGE_IDLE;
        end else begin
            stage <= global_stage;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            parent_vector <= '0;
            odd <= 1'b0;
            odd_to_children <= '0;
            busy <= 1'b0;
            peel_complete <= 1'b0;
            peel_parity_done <= 1'b0;
        end else begin
            case (stage)
                STAGE_MEASUREMENT_LOADING: begin
                    parent_vector <= '0;
                    odd <= measurement;
                    odd_to_children <= {NEIGHBOR_COUNT{measurement}};
                    busy <= 1'b0;
                    peel_complete <= 1'b0;
                    peel_parity_done <= 1'b0;
                end
                STAGE_MERGE: begin
                    if (adopt) begin
                        parent_vector <= win_valids;
                    end
                    odd <= next_odd;
                    odd_to_children <= {NEIGHBOR_COUNT{next_odd}};
                    busy <= adopt || (next_parity != cluster_parity) ||
                            (next_boundary != cluster_boundary) || (next_odd != odd);
                end
                STAGE_PEELING: begin
                    odd <= carry & at_boundary; // This unit takes the boundary defect
                    odd_to_children <= (carry & ~at_boundary) ?
                                       lowest_one(nb_child & child_boundary) : '0;
                    peel_parity_done <= (|parent_vector) ? (|(parent_vector & parent_done)) : 1'b1;
                    peel_complete <= ready;
                    busy <= !ready;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (stage == STAGE_MEASUREMENT_LOADING) begin
            m <= measurement;
            root <= ADDRESS_WIDTH'(ADDRESS);
            cluster_parity <= measurement;
            cluster_boundary <= 1'b0;
            peel_m <= 1'b0;
        end else if (stage == STAGE_MERGE) begin
            if (adopt) begin
                root <= win_root;
            end
            cluster_parity <= next_parity;
            cluster_boundary <= next_boundary;
        end else if (stage == STAGE_PEELING && ready) begin
            peel_m <= m ^ (^(nb_child & child_m)) ^ odd; // Residual defect sent up
        end
    end

endmodule

`default_nettype wire

//--- hw/stage_controller.sv
`default_nettype none

module stage_controller #(
    parameter int MAX_ROUNDS = 15
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start,
    input  logic                   any_busy,
    input  logic                   any_odd,
    output uf_decoder_pkg::stage_t stage,
    output logic                   done,
    output logic [3:0]             rounds
);
    import uf_decoder_pkg::*;

    localparam int SETTLE_WIDTH = $clog2(MERGE_SETTLE);
    localparam logic [SETTLE_WIDTH-1:0] SETTLE_LAST = SETTLE_WIDTH'(MERGE_SETTLE - 1);

    logic [SETTLE_WIDTH-1:0] settle_count;
    logic settled;

    // Busy is only current from the last settle cycle on
    assign settled = (settle_count == SETTLE_LAST) && !any_busy;

    always_ff @(posedge clk) begin
        if (reset) begin
            settle_count <= '0;
        end else if (stage != STAGE_MERGE && stage != STAGE_PEELING) begin
            settle_count <= '0;
        end else if (settled) begin
            settle_count <= '0;
        end else if (settle_count != SETTLE_LAST) begin
            settle_count <= settle_count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stage <= STAGE_IDLE;
            rounds <= 4'd0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            case (stage)
                STAGE_IDLE: begin
                    if (start) begin
                        stage <= STAGE_MEASUREMENT_LOADING;
                        rounds <= 4'd0;
                    end
                end
                STAGE_MEASUREMENT_LOADING: stage <= STAGE_GROW;
                STAGE_GROW: stage <= STAGE_MERGE;
                STAGE_MERGE: begin
                    if (settled) begin
                        if (any_odd && rounds < MAX_ROUNDS) begin
                            stage <= STAGE_GROW;
                            rounds <= rounds + 4'd1;
                        end else begin
                            stage <= STAGE_PEELING; // Converged or out of rounds
                        end
                    end
                end
                STAGE_PEELING: begin
                    if (settled) begin
                        stage <= STAGE_RESULT;
                    end
                end
                STAGE_RESULT: begin
                    stage <= STAGE_IDLE;
                    done <= 1'b1;
                end
                default: stage <= STAGE_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/uf_line_decoder.sv
`default_nettype none

module uf_line_decoder #(
    parameter int PE_COUNT      = 6,
    parameter int ADDRESS_WIDTH = 3
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  logic [PE_COUNT-1:0] measurements,
    output logic [PE_COUNT:0]   correction,
    output logic                done,
    output logic [3:0]          rounds
);
    import uf_decoder_pkg::*;

    localparam int MAX_ROUNDS = 15;

    stage_t stage;
    logic [PE_COUNT-1:0] unit_busy;
    logic [PE_COUNT-1:0] unit_odd;
    logic any_busy;
    logic any_odd;

    // Edge e sits between unit e-1 and unit e
    neighbor_link_if #(.ADDRESS_WIDTH(ADDRESS_WIDTH)) link_bus [0:PE_COUNT] ();

    // Boundary edges have one unit only
    assign link_bus[0].increase_low = 1'b0;
    assign link_bus[0].error_low = 1'b0;
    assign link_bus[0].data_up = '0;
    assign link_bus[PE_COUNT].increase_high = 1'b0;
    assign link_bus[PE_COUNT].error_high = 1'b0;
    assign link_bus[PE_COUNT].data_down = '0;

    assign any_busy = |unit_busy;
    assign any_odd = |unit_odd;

    stage_controller #(
        .MAX_ROUNDS(MAX_ROUNDS)
    ) stage_controller_i (
        .clk     (clk),
        .reset   (reset),
        .start   (start),
        .any_busy(any_busy),
        .any_odd (any_odd),
        .stage   (stage),
        .done    (done),
        .rounds  (rounds)
    );

    for (genvar i = 0; i < PE_COUNT; i++) begin : unit_g
        processing_unit #(
            .ADDRESS_WIDTH(ADDRESS_WIDTH),
            .ADDRESS      (i)
        ) processing_unit_i (
            .clk         (clk),
            .reset       (reset),
            .global_stage(stage),
            .measurement (measurements[i]),
            .low_edge    (link_bus[i]),
            .high_edge   (link_bus[i+1]),
            .odd         (unit_odd[i]),
            .busy        (unit_busy[i])
        );
    end

    for (genvar e = 0; e <= PE_COUNT; e++) begin : link_g
        neighbor_link #(
            .IS_BOUNDARY(e == 0 || e == PE_COUNT)
        ) neighbor_link_i (
            .clk         (clk),
            .reset       (reset),
            .global_stage(stage),
            .link        (link_bus[e]),
            .marked      (correction[e])
        );
    end

endmodule

`default_nettype wire

//--- tests/uf_line_decoder_props.sv
`default_nettype none

module stage_controller_props #(
    parameter int MAX_ROUNDS = 15
) (
    input logic                   clk,
    input logic                   reset,
    input uf_decoder_pkg::stage_t stage,
    input logic                   done,
    input logic [3:0]             rounds
);
    import uf_decoder_pkg::*;

    logic [7:0] merge_cycles;

    // Length of the current merge stay, saturating
    always_ff @(posedge clk) begin
        if (reset || stage != STAGE_MERGE) begin
            merge_cycles <= 8'd0;
        end else if (merge_cycles != 8'hff) begin
            merge_cycles <= merge_cycles + 8'd1;
        end
    end

    done_single: assert property (@(posedge clk) disable iff (reset) done |=> !done)
        else $error("done held high for more than one cycle");

    done_after_result: assert property (@(posedge clk) disable iff (reset)
        done |-> $past(stage) == STAGE_RESULT)
        else $error("done without a preceding result stage");

    load_then_grow: assert property (@(posedge clk) disable iff (reset)
        stage == STAGE_MEASUREMENT_LOADING |=> stage == STAGE_GROW)
        else $error("measurement loading not followed by grow");

    merge_settle: assert property (@(posedge clk) disable iff (reset)
        (stage != STAGE_MERGE && $past(stage) == STAGE_MERGE) |-> merge_cycles >= MERGE_SETTLE)
        else $error("merge left before the settle time");

    // A further round may only start below the limit
    rounds_limit: assert property (@(posedge clk) disable iff (reset)
        (stage == STAGE_GROW && $past(stage) == STAGE_MERGE) |-> $past(rounds) < MAX_ROUNDS)
        else $error("new round started at the round limit");

endmodule

bind stage_controller stage_controller_props #(
    .MAX_ROUNDS(MAX_ROUNDS)
) stage_controller_props_i (
    .clk   (clk),
    .reset (reset),
    .stage (stage),
    .done  (done),
    .rounds(rounds)
);

`default_nettype wire

//--- tests/uf_line_decoder_tb.sv
`default_nettype none

module uf_line_decoder_tb;

    localparam int PE_COUNT = 6;
    localparam int DONE_TIMEOUT = 400;

    logic clk;
    logic reset;
    logic start;
    logic [PE_COUNT-1:0] measurements;
    logic [PE_COUNT:0] correction;
    logic done;
    logic [3:0] rounds;

    int mismatch_count;
    int failure_count;
    logic [16:0] lfsr_state;

    uf_line_decoder uf_line_decoder_i (
        .clk         (clk),
        .reset       (reset),
        .start       (start),
        .measurements(measurements),
        .correction  (correction),
        .done        (done),
        .rounds      (rounds)
    );

    always #20 clk = ~clk;

    // Taps 17 and 14
    function automatic logic [16:0] lfsr_next(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};
    endfunction

    task automatic check_correction(input string test, input logic [PE_COUNT:0] expected);
        if (correction !== expected) begin
            $display("mismatch %s: correction expected %b actual %b", test, expected, correction);
            mismatch_count++;
        end
    endtask

    task automatic check_rounds(input string test, input logic [3:0] expected);
        if (rounds !== expected) begin
            $display("mismatch %s: rounds expected %0d actual %0d", test, expected, rounds);
            mismatch_count++;
        end
    endtask

    task automatic check_syndrome(input string test, input logic [PE_COUNT-1:0] expected,
                                  input logic [PE_COUNT-1:0] actual);
        if (actual !== expected) begin
            $display("mismatch %s: syndrome expected %b actual %b", test, expected, actual);
            mismatch_count++;
        end
    endtask

    task automatic wait_done(input string test);
        int cycles;
        cycles = 0;
        while (!done && cycles < DONE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!done) begin
            $display("%s: done never arrived within %0d cycles", test, DONE_TIMEOUT);
            failure_count++;
        end
    endtask

    task automatic start_decode(input logic [PE_COUNT-1:0] syndrome);
        @(negedge clk);
        measurements = syndrome;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic decode(input string test, input logic [PE_COUNT-1:0] syndrome);
        start_decode(syndrome);
        wait_done(test);
    endtask

    task automatic test_idle();
        repeat (10) begin
            @(negedge clk);
            if (done) begin
                $display("idle: done pulsed without a start");
                failure_count++;
            end
            check_correction("idle", '0);
        end
    endtask

    task automatic test_zero();
        decode("zero", '0);
        check_correction("zero", '0);
        check_rounds("zero", 4'd0);
    endtask

    task automatic test_boundary();
        decode("boundary_low", PE_COUNT'(1));
        check_correction("boundary_low", (PE_COUNT+1)'(1));
        check_rounds("boundary_low", 4'd1); // Weight 2 needs a second grow round
        decode("boundary_high", PE_COUNT'(1) << (PE_COUNT - 1));
        check_correction("boundary_high", (PE_COUNT+1)'(1) << PE_COUNT);
        check_rounds("boundary_high", 4'd1);
    endtask

    task automatic test_adjacent();
        string name;
        for (int k = 0; k < PE_COUNT - 1; k++) begin
            name = $sformatf("adjacent_%0d", k);
            decode(name, PE_COUNT'(3) << k);
            check_correction(name, (PE_COUNT+1)'(1) << (k + 1)); // Edge between the pair
        end
    endtask

    task automatic test_random();
        logic [PE_COUNT-1:0] syndrome;
        logic [PE_COUNT-1:0] parity;
        string name;
        for (int n = 0; n < 30; n++) begin
            for (int b = 0; b < PE_COUNT; b++) begin
                syndrome[b] = lfsr_state[0];
                lfsr_state = lfsr_next(lfsr_state);
            end
            name = $sformatf("random_%0d", n);
            decode(name, syndrome);
            for (int i = 0; i < PE_COUNT; i++) begin
                parity[i] = correction[i] ^ correction[i+1]; // Each unit sees its two edges
            end
            check_syndrome(name, syndrome, parity);
        end
    endtask

    task automatic test_restart();
        int extra_done;
        extra_done = 0;
        start_decode(PE_COUNT'(1));
        repeat (5) @(negedge clk);
        measurements = PE_COUNT'(1) << (PE_COUNT - 1);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        wait_done("restart");
        check_correction("restart", (PE_COUNT+1)'(1));
        repeat (20) begin
            @(negedge clk);
            if (done) extra_done++;
        end
        if (extra_done != 0) begin
            $display("restart: a second done followed the start given during a decode");
            failure_count++;
        end
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        start = 1'b0;
        measurements = '0;
        mismatch_count = 0;
        failure_count = 0;
        lfsr_state = 17'd91745;
        repeat (4) @(negedge clk);
        reset = 1'b0;

        test_idle();
        test_zero();
        test_boundary();
        test_adjacent();
        test_random();
        test_restart();

        $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- uf_line_decoder.f
hw/uf_decoder_pkg.sv
hw/neighbor_link_if.sv
hw/root_min_select.sv
hw/neighbor_link.sv
hw/processing_unit.sv
hw/stage_controller.sv
hw/uf_line_decoder.sv
tests/uf_line_decoder_props.sv
tests/uf_line_decoder_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module uf_line_decoder_tb \
    -f uf_line_decoder.f \
    -Mdir obj_dir -o uf_line_decoder_sim

./obj_dir/uf_line_decoder_sim | tee sim.log

if grep -q "^Regression passed$" sim.log; then
    exit 0
fi
exit 1
